//--- freq_meter.f
+incdir+.
freq_meter_pkg.sv
frequency_analyzer_synch.sv
signal_conditioner.sv
frequency_analyzer.sv
measurement_control.sv
freq_meter_top.sv
freq_meter_assert.sv
freq_meter_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the frequency meter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module freq_meter_tb -f freq_meter.f -o freq_meter_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/freq_meter_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

//--- freq_meter_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "freq_meter_cfg.svh"

module freq_meter_tb;

    localparam integer GATE = `FREQ_METER_CLOCK_HZ / `FREQ_METER_GATE_HZ;
    localparam integer RESULT_TIMEOUT = 2000;   // cycles allowed per result.

    logic clock = 1'b0;
    logic reset = 1'b0;
    logic enable = 1'b0;
    logic signal_in = 1'b0;
    freq_meter_pkg::count_t result;
    logic result_channel;
    freq_meter_pkg::index_t result_index;
    logic result_overflow;
    logic result_valid;

    integer period = 10;        // 0 means a flat line.
    integer phase = 0;
    logic glitch_on = 1'b0;
    logic check_counts = 1'b0;
    logic in_pause = 1'b0;
    logic in_reset = 1'b0;
    integer resume_state = 0;   // results still to see before alternation settles.
    logic exp_channel = 1'b1;
    integer exp_index = 0;
    integer results_seen = 0;
    integer error_count = 0;
    integer expected_value;
    integer diff;
    integer tolerance;
    logic [31:0] rand_state = 32'h502e94fc;
    integer i;

    freq_meter_top dut_i
    (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .signal_in(signal_in),
        .result(result),
        .result_channel(result_channel),
        .result_index(result_index),
        .result_overflow(result_overflow),
        .result_valid(result_valid)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // channel 0 gates last F+D+1 cycles and channel 1 gates last F.
    function automatic integer expected_count(input logic channel, input integer p);
        integer g;
        g = channel ? GATE : GATE + `FREQ_METER_STROBE_CYCLES + 1;
        if (p == 0)
            return 0;
        return g / p;
    endfunction

    // square wave that is high for the first half of each period.
    always @(posedge clock)
    begin
        if (period == 0)
        begin
            signal_in <= 1'b0;
            phase <= 0;
        end
        else
        begin
            phase <= (phase + 1 >= period) ? 0 : phase + 1;
            signal_in <= (phase < period / 2) || (glitch_on && phase == (period * 3) / 4);
        end
    end

    always @(posedge clock)
    begin
        if (in_reset && result_valid)
        begin
            $display("time %0t: result_valid seen while reset is held", $time);
            error_count = error_count + 1;
        end
        if (in_pause && result_valid)
        begin
            $display("time %0t: result_valid seen while enable is low", $time);
            error_count = error_count + 1;
        end
        if (reset && !in_reset && result_valid)
        begin
            exp_index = exp_index + 1;
            if (result_index !== freq_meter_pkg::index_t'(exp_index))
            begin
                $display("** Error %0t result_index: got %0d expected %0d",
                         $time, result_index, exp_index);
                error_count = error_count + 1;
            end
            if (resume_state != 1 && result_channel !== exp_channel)
            begin
                $display("** Error %0t result_channel: got %0d expected %0d",
                         $time, result_channel, exp_channel);
                error_count = error_count + 1;
            end
            // a paused gate is split in two and a flat line has no edges.
            tolerance = (resume_state != 0) ? 2 : ((period == 0) ? 0 : 1);
            expected_value = expected_count(result_channel, period);
            diff = integer'(result) - expected_value;
            if (diff < 0)
                diff = -diff;
            if (check_counts && diff > tolerance)
            begin
                $display("** Error %0t result: got %0d expected %0d",
                         $time, result, expected_value);
                error_count = error_count + 1;
            end
            if (result_overflow !== 1'b0)
            begin
                $display("** Error %0t result_overflow: got %0d expected 0",
                         $time, result_overflow);
                error_count = error_count + 1;
            end
            if (resume_state > 0)
                resume_state = resume_state - 1;
            exp_channel = ~result_channel;
            results_seen = results_seen + 1;
        end
    end

    task automatic wait_results(input integer n);
        integer target;
        integer cycles;
        target = results_seen + n;
        cycles = 0;
        while (results_seen < target)
        begin
            @(posedge clock);
            cycles = cycles + 1;
            if (cycles > RESULT_TIMEOUT * n)
            begin
                $display("timeout, no result_valid after %0d cycles", cycles);
                $display("Test failed");
                $finish;
            end
        end
    endtask

    // skip the gates that straddle the change, then check two gate cycles.
    task automatic measure_period(input integer p);
        check_counts = 1'b0;
        period = p;
        wait_results(4);
        check_counts = 1'b1;
        wait_results(4);
    endtask

    task automatic report_test(input string name);
        $display("test %s finished, errors so far %0d", name, error_count);
    endtask

    initial
    begin
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        enable <= 1'b1;

        measure_period(10);
        measure_period(7);
        measure_period(25);
        report_test("steady waves");
        if (result_index !== freq_meter_pkg::index_t'(results_seen))
        begin
            $display("** Error %0t result_index: got %0d expected %0d",
                     $time, result_index, results_seen);
            error_count = error_count + 1;
        end
        report_test("measurement index");

        for (i = 0; i < 6; i = i + 1)
        begin
            rand_state = lcg_next(rand_state);
            measure_period(4 + integer'(rand_state[23:8] % 37));
        end
        report_test("random periods");

        rand_state = lcg_next(rand_state);
        @(posedge clock);
        enable <= 1'b0;
        repeat (4) @(posedge clock);
        in_pause = 1'b1;
        repeat (20 + integer'(rand_state[23:8] % 200)) @(posedge clock);
        in_pause = 1'b0;
        enable <= 1'b1;
        exp_channel = 1'b1;
        resume_state = 2;
        wait_results(4);
        report_test("pause and resume");

        glitch_on = 1'b1;
        measure_period(40);
        glitch_on = 1'b0;
        report_test("glitch filter");

        measure_period(0);
        @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);
        in_reset = 1'b1;
        repeat (10) @(posedge clock);
        if (result_index !== '0)
        begin
            $display("** Error %0t result_index: got %0d expected 0", $time, result_index);
            error_count = error_count + 1;
        end
        in_reset = 1'b0;
        exp_index = 0;
        exp_channel = 1'b1;
        reset <= 1'b1;
        wait_results(4);
        report_test("flat line and reset");

        $display("results %0d, errors %0d", results_seen, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- freq_meter_assert.sv
`default_nettype none
`timescale 1ns/1ps

module freq_meter_assert
(
    input wire logic clock,
    input wire logic reset,
    input wire logic start_analyzer_0,
    input wire logic stop_analyzer_0,
    input wire logic start_analyzer_1,
    input wire logic stop_analyzer_1,
    input wire logic result_valid
);

    assert property (@(posedge clock) disable iff (!reset)
                     !(start_analyzer_0 && start_analyzer_1))
        else $error("both start strobes high");

    assert property (@(posedge clock) disable iff (!reset)
                     !(stop_analyzer_1 && start_analyzer_1))
        else $error("channel 1 start and stop high together");

    assert property (@(posedge clock) disable iff (!reset)
                     result_valid |=> !result_valid)
        else $error("result_valid longer than one cycle");

    // registers clear on the edge that samples reset low.
    assert property (@(posedge clock) !reset |=> !(start_analyzer_0 || stop_analyzer_0 ||
                     start_analyzer_1 || stop_analyzer_1 || result_valid))
        else $error("strobe high during reset");

endmodule

bind frequency_analyzer_synch freq_meter_assert synch_assert_i
(
    .clock(clock),
    .reset(reset),
    .start_analyzer_0(start_analyzer_0),
    .stop_analyzer_0(stop_analyzer_0),
    .start_analyzer_1(start_analyzer_1),
    .stop_analyzer_1(stop_analyzer_1),
    .result_valid(1'b0)
);

bind freq_meter_top freq_meter_assert top_assert_i
(
    .clock(clock),
    .reset(reset),
    .start_analyzer_0(start_analyzer_0),
    .stop_analyzer_0(stop_analyzer_0),
    .start_analyzer_1(start_analyzer_1),
    .stop_analyzer_1(stop_analyzer_1),
    .result_valid(result_valid)
);

`default_nettype wire

//--- freq_meter_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "freq_meter_cfg.svh"

module freq_meter_top
(
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic signal_in,
    output freq_meter_pkg::count_t result,
    output logic result_channel,
    output freq_meter_pkg::index_t result_index,
    output logic result_overflow,
    output logic result_valid
);

    logic run;
    logic edge_pulse;
    logic start_analyzer_0;
    logic stop_analyzer_0;
    logic start_analyzer_1;
    logic stop_analyzer_1;
    freq_meter_pkg::count_t count_0;
    freq_meter_pkg::count_t count_1;
    logic overflow_0;
    logic overflow_1;
    logic done_0;
    logic done_1;

    signal_conditioner conditioner_i
    (
        .clock(clock),
        .reset(reset),
        .signal_in(signal_in),
        .edge_pulse(edge_pulse)
    );

    frequency_analyzer_synch #
    (
        .CLOCK(`FREQ_METER_CLOCK_HZ),
        .FREQUENCY(`FREQ_METER_GATE_HZ),
        .SIGNAL_DELAY(`FREQ_METER_STROBE_CYCLES)
    )
    synch_i
    (
        .clock(clock),
        .reset(reset),
        .run(run),
        .start_analyzer_0(start_analyzer_0),
        .stop_analyzer_0(stop_analyzer_0),
        .start_analyzer_1(start_analyzer_1),
        .stop_analyzer_1(stop_analyzer_1)
    );

    frequency_analyzer #
    (
        .COUNT_WIDTH(`FREQ_METER_COUNT_WIDTH)
    )
    analyzer_0_i
    (
        .clock(clock),
        .reset(reset),
        .run(run),
        .start(start_analyzer_0),
        .stop(stop_analyzer_0),
        .edge_pulse(edge_pulse),
        .count(count_0),
        .overflow(overflow_0),
        .done(done_0)
    );

    frequency_analyzer #
    (
        .COUNT_WIDTH(`FREQ_METER_COUNT_WIDTH)
    )
    analyzer_1_i
    (
        .clock(clock),
        .reset(reset),
        .run(run),
        .start(start_analyzer_1),
        .stop(stop_analyzer_1),
        .edge_pulse(edge_pulse),
        .count(count_1),
        .overflow(overflow_1),
        .done(done_1)
    );

    measurement_control control_i
    (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .run(run),
        .done_0(done_0),
        .count_0(count_0),
        .overflow_0(overflow_0),
        .done_1(done_1),
        .count_1(count_1),
        .overflow_1(overflow_1),
        .result(result),
        .result_channel(result_channel),
        .result_index(result_index),
        .result_overflow(result_overflow),
        .result_valid(result_valid)
    );

endmodule

`default_nettype wire

//--- measurement_control.sv
`default_nettype none
`timescale 1ns/1ps

module measurement_control
(
    input  logic clock,
    input  logic reset,
    input  logic enable,
    output logic run,
    input  logic done_0,
    input  freq_meter_pkg::count_t count_0,
    input  logic overflow_0,
    input  logic done_1,
    input  freq_meter_pkg::count_t count_1,
    input  logic overflow_1,
    output freq_meter_pkg::count_t result,
    output logic result_channel,
    output freq_meter_pkg::index_t result_index,
    output logic result_overflow,
    output logic result_valid
);

    logic primed;       // low until the short channel 0 gate has been dropped.
    logic publish_0;

    assign publish_0 = done_0 & primed;

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            run <= 1'b0;
            primed <= 1'b0;
            result_index <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            run <= enable;
            result_valid <= publish_0 | done_1;
            if (done_0)
                primed <= 1'b1;
            if (enable && !run)
                primed <= 1'b0;                          // a new run starts with a short gate.
            if (publish_0 || done_1)
                result_index <= result_index + 1'b1;
        end
    end

    // the two stop levels never rise together, so at most one done per cycle.
    always_ff @(posedge clock)
    begin
        if (publish_0)
        begin
            result <= count_0;
            result_channel <= 1'b0;
            result_overflow <= overflow_0;
        end
        else if (done_1)
        begin
            result <= count_1;
            result_channel <= 1'b1;
            result_overflow <= overflow_1;
        end
    end

endmodule

`default_nettype wire

//--- frequency_analyzer.sv
`default_nettype none
`timescale 1ns/1ps

`include "freq_meter_cfg.svh"

module frequency_analyzer #
(
    parameter integer COUNT_WIDTH = `FREQ_METER_COUNT_WIDTH
)
(
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic start,
    input  logic stop,
    input  logic edge_pulse,
    output freq_meter_pkg::count_t count,
    output logic overflow,
    output logic done
);

    localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = {COUNT_WIDTH{1'b1}};

    freq_meter_pkg::analyzer_state_e state;
    logic [COUNT_WIDTH-1:0] edge_count;
    logic edge_overflow;
    logic start_q;
    logic start_q2;
    logic stop_q;
    logic stop_q2;
    logic start_rise;
    logic stop_rise;

    assign start_rise = start_q & ~start_q2;
    assign stop_rise = stop_q & ~stop_q2;

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            state <= freq_meter_pkg::analyzer_idle;
            start_q <= 1'b0;
            start_q2 <= 1'b0;
            stop_q <= 1'b0;
            stop_q2 <= 1'b0;
            edge_count <= '0;
            edge_overflow <= 1'b0;
            count <= '0;
            overflow <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (run)
            begin
                start_q <= start;
                start_q2 <= start_q;
                stop_q <= stop;
                stop_q2 <= stop_q;
                case (state)
                    freq_meter_pkg::analyzer_idle:
                    begin
                        if (start_rise)
                        begin
                            edge_count <= '0;
                            edge_overflow <= 1'b0;
                            state <= freq_meter_pkg::analyzer_counting;
                        end
                    end
                    freq_meter_pkg::analyzer_counting:
                    begin
                        if (stop_rise)
                        begin
                            count <= freq_meter_pkg::count_t'(edge_count);
                            overflow <= edge_overflow;
                            done <= 1'b1;
                            state <= freq_meter_pkg::analyzer_idle;
                        end
                        else if (edge_pulse)
                        begin
                            if (edge_count == COUNT_MAX)
                                edge_overflow <= 1'b1;          // sticky until next gate.
                            else
                                edge_count <= edge_count + 1'b1;
                        end
                    end
                    default: state <= freq_meter_pkg::analyzer_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- signal_conditioner.sv
`default_nettype none
`timescale 1ns/1ps

module signal_conditioner
(
    input  logic clock,
    input  logic reset,
    input  logic signal_in,
    output logic edge_pulse
);

    logic [1:0] sync_ff;    // two-flop synchronizer.
    logic [1:0] history;    // two older samples.
    logic [2:0] samples;
    logic filtered;
    logic filtered_q;

    assign samples = {history, sync_ff[1]};

    // two of three samples must agree.
    assign filtered = (samples[0] & samples[1]) | (samples[1] & samples[2]) |
                      (samples[0] & samples[2]);

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            sync_ff <= 2'b00;
            history <= 2'b00;
            filtered_q <= 1'b0;
            edge_pulse <= 1'b0;
        end
        else
        begin
            sync_ff <= {sync_ff[0], signal_in};
            history <= {history[0], sync_ff[1]};
            filtered_q <= filtered;
            edge_pulse <= filtered & ~filtered_q;   // one cycle per rising edge.
        end
    end

endmodule

`default_nettype wire

//--- frequency_analyzer_synch.sv
`default_nettype none
`timescale 1ns/1ps

`include "freq_meter_cfg.svh"

module frequency_analyzer_synch #
(
    parameter integer CLOCK = `FREQ_METER_CLOCK_HZ,
    parameter integer FREQUENCY = `FREQ_METER_GATE_HZ,
    parameter integer SIGNAL_DELAY = `FREQ_METER_STROBE_CYCLES
)
(
    input  logic clock,
    input  logic reset,
    input  logic run,
    output logic start_analyzer_0,
    output logic stop_analyzer_0,
    output logic start_analyzer_1,
    output logic stop_analyzer_1
);

    localparam integer GATE_CYCLES = CLOCK / FREQUENCY;

    // boundaries of the alternating gate cycle.
    localparam freq_meter_pkg::tick_t DELAY_END = freq_meter_pkg::tick_t'(SIGNAL_DELAY);
    localparam freq_meter_pkg::tick_t HANDOVER_START = freq_meter_pkg::tick_t'(GATE_CYCLES);
    localparam freq_meter_pkg::tick_t HANDOVER_END =
        freq_meter_pkg::tick_t'(GATE_CYCLES + SIGNAL_DELAY);
    localparam freq_meter_pkg::tick_t RETURN_START = freq_meter_pkg::tick_t'(2 * GATE_CYCLES);
    localparam freq_meter_pkg::tick_t CYCLE_LAST =
        freq_meter_pkg::tick_t'(2 * GATE_CYCLES + SIGNAL_DELAY);

    freq_meter_pkg::tick_t tick;
    logic in_handover;
    logic in_return;

    assign in_handover = (tick >= HANDOVER_START) && (tick < HANDOVER_END);
    assign in_return = (tick >= RETURN_START);

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            tick <= '0;
        end
        else if (run)
        begin
            if (tick >= CYCLE_LAST)
                tick <= '0;
            else
                tick <= tick + 1'b1;
        end
    end

    // strobes lag the counter by one cycle and freeze while paused.
    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            start_analyzer_0 <= 1'b0;
            stop_analyzer_0 <= 1'b0;
            start_analyzer_1 <= 1'b0;
            stop_analyzer_1 <= 1'b0;
        end
        else if (run)
        begin
            start_analyzer_0 <= (tick < DELAY_END) || in_return;   // spans the wrap.
            stop_analyzer_0 <= in_handover;
            start_analyzer_1 <= in_handover;
            stop_analyzer_1 <= in_return;
        end
    end

endmodule

`default_nettype wire

//--- freq_meter_pkg.sv
`default_nettype none

`include "freq_meter_cfg.svh"

package freq_meter_pkg;

    typedef logic [`FREQ_METER_COUNT_WIDTH-1:0] count_t;   // rising edges in one gate.
    typedef logic [15:0] tick_t;                           // sequencer cycle position.
    typedef logic [15:0] index_t;                          // published measurement number.

    typedef enum logic
    {
        analyzer_idle,
        analyzer_counting
    } analyzer_state_e;

endpackage

`default_nettype wire

//--- freq_meter_cfg.svh
`ifndef FREQ_METER_CFG_SVH
`define FREQ_METER_CFG_SVH

// system clock rate in hertz.
`define FREQ_METER_CLOCK_HZ 1000000

// gate rate in hertz, the gate period is the clock rate over this rate.
`define FREQ_METER_GATE_HZ 10000

// width of the start and stop strobe windows in clock cycles.
`define FREQ_METER_STROBE_CYCLES 4

// width of an edge count.
`define FREQ_METER_COUNT_WIDTH 16

`endif
